/* src/colmix_pkg.sv */
// colour mixer package: pixel and palette widths, colour type and road modes
package colmix_pkg;

    // sprite pixel width, 13-bit variant only
    localparam int obj_w = 13;

    // palette word address, bit 11 always zero in this variant
    localparam int pal_aw = 12;

    // one colour component
    localparam int col_w = 5;

    // 15-bit colour, red in the top bits
    typedef struct packed {
        logic [col_w-1:0] red;
        logic [col_w-1:0] green;
        logic [col_w-1:0] blue;
    } rgb_t;

    // road control bits rc[4:3]
    // low0/low1 force the upper road colour bits to 11
    // half takes road pixel bit 4 with a leading zero
    // full takes road pixel bits 5:4
    typedef enum logic [1:0] {
        road_low0 = 2'b00,
        road_low1 = 2'b01,
        road_half = 2'b10,
        road_full = 2'b11
    } road_mode_e;

    // palette word layout, 16 bits
    //   red   = {word[3:0],  word[12]}
    //   green = {word[7:4],  word[13]}
    //   blue  = {word[11:8], word[14]}
    //   word[15] set means the colour ignores shadow
    // lsb of each component sits in the upper nibble area of the word

endpackage

/* src/pal_cpu_if.sv */
// CPU palette bus: select, word address, write data, byte strobes and read data
interface pal_cpu_if;
    import colmix_pkg::*;

    // chip select from the CPU address decoder
    logic              cs;
    // palette word address
    logic [pal_aw-1:0] addr;
    // write data from the CPU
    logic [15:0]       dout;
    // byte strobes, active low, bit 1 is the upper byte
    logic [1:0]        dswn;
    // read data back to the CPU, one clk after addr
    logic [15:0]       din;

    modport cpu (
        output cs, addr, dout, dswn,
        input  din
    );

    modport ram (
        input  cs, addr, dout, dswn,
        output din
    );
endinterface

/* src/pal_ram.sv */
// palette RAM: byte-writable CPU port and a registered video read port
module pal_ram (
    input  logic                         clk,
    pal_cpu_if.ram                       cpu,
    input  logic [colmix_pkg::pal_aw-1:0] vaddr,
    output logic [15:0]                  vdata
);
    import colmix_pkg::*;

    localparam int depth = 2 ** pal_aw;

    // palette storage, contents come from the CPU only
    logic [15:0] mem [depth];

    // per-byte write enables
    logic [1:0] we;

    // a byte is written when selected and its strobe is low
    assign we = ~cpu.dswn & {2{cpu.cs}};

    // CPU port
    always_ff @(posedge clk) begin
        // lower byte
        if (we[0]) begin
            mem[cpu.addr][7:0] <= cpu.dout[7:0];
        end
        // upper byte
        if (we[1]) begin
            mem[cpu.addr][15:8] <= cpu.dout[15:8];
        end
        // read back regardless of cs
        // old word shows if written in the same clk
        cpu.din <= mem[cpu.addr];
    end

    // video port, read on every clk
    // the pixel pipeline picks it up on the next pxl_cen
    always_ff @(posedge clk) begin
        vdata <= mem[vaddr];
    end

endmodule

/* src/layer_select.sv */
// layer select: road or tile-map priority and registered palette address
module layer_select (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          pxl_cen,
    input  logic [10:0]                   tmap_addr,
    input  logic [colmix_pkg::obj_w-1:0]  obj_pxl,
    input  logic [7:0]                    rd_pxl,
    input  colmix_pkg::road_mode_e        rc,
    input  logic                          sa,
    input  logic                          sb,
    input  logic                          fix,
    input  logic                          shadow,
    output logic [colmix_pkg::pal_aw-1:0] pal_addr,
    output logic                          pal_shadow
);
    import colmix_pkg::*;

    // raw rc[4:3] bits
    logic [1:0]  rc_bits;
    // upper road colour bits
    logic [1:0]  road_hi;
    logic [10:0] road_addr;
    logic [10:0] next_addr;
    // high picks the road layer
    logic        road_sel;

    assign rc_bits = rc;

    // road colour bits 5:4 depend on the mode
    always_comb begin
        road_hi = 2'b11;
        case (rc)
            road_low0: road_hi = 2'b11;
            road_low1: road_hi = 2'b11;
            road_half: road_hi = {1'b0, rd_pxl[4]};
            road_full: road_hi = rd_pxl[5:4];
        endcase
    end

    // bank bits follow rc bit 4
    assign road_addr = {{5{rc_bits[1]}}, road_hi, rd_pxl[3:0]};

    // fix layer always wins
    // transparent sprite shows road unless rc3 set and sa/sb active
    // sprite code 10xx...0101 also opens the road
    assign road_sel = !fix && (
        (obj_pxl[3:0] == 4'h0 && (!rc_bits[0] || (!sa && !sb))) ||
        (obj_pxl[11:10] == 2'b10 && obj_pxl[3:0] == 4'b0101));

    assign next_addr = road_sel ? road_addr : tmap_addr;

    // address and shadow move together so they meet the RAM word
    always_ff @(posedge clk) begin
        if (reset) begin
            pal_addr   <= '0;
            pal_shadow <= 1'b0;
        end else if (pxl_cen) begin
            // bit 11 unused in this variant
            pal_addr   <= {1'b0, next_addr};
            pal_shadow <= shadow;
        end
    end

endmodule

/* src/blank_delay.sv */
// blanking delay: aligns colour and blanking, black outside the active area
module blank_delay #(
    parameter int blank_dly = 2
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             pxl_cen,
    input  logic             preLHBL,
    input  logic             preLVBL,
    input  colmix_pkg::rgb_t rgb_in,
    output logic             LHBL,
    output logic             LVBL,
    output colmix_pkg::rgb_t rgb_out
);
    import colmix_pkg::*;

    // colour line, blank_dly stages
    rgb_t rgb_sr [blank_dly];

    // blanking lines, two extra stages cover the address and RAM steps
    logic [blank_dly+1:0] lhbl_sr;
    logic [blank_dly+1:0] lvbl_sr;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < blank_dly; i++) begin
                rgb_sr[i] <= '0;
            end
            lhbl_sr <= '0;
            lvbl_sr <= '0;
        end else if (pxl_cen) begin
            rgb_sr[0] <= rgb_in;
            for (int i = 1; i < blank_dly; i++) begin
                rgb_sr[i] <= rgb_sr[i-1];
            end
            // newest sample enters at bit 0
            lhbl_sr <= {lhbl_sr[blank_dly:0], preLHBL};
            lvbl_sr <= {lvbl_sr[blank_dly:0], preLVBL};
        end
    end

    assign LHBL = lhbl_sr[blank_dly+1];
    assign LVBL = lvbl_sr[blank_dly+1];

    // black during either blanking
    assign rgb_out = (LHBL && LVBL) ? rgb_sr[blank_dly-1] : '0;

endmodule

/* src/colmix.sv */
// colour stage: palette word unpack, shadow dimming and video enable
module colmix (
    input  logic             clk,
    input  logic             reset,
    input  logic             pxl_cen,
    input  logic             video_en,
    input  logic [15:0]      pal_word,
    input  logic             pal_shadow,
    output colmix_pkg::rgb_t rgb
);
    import colmix_pkg::*;

    // colour as stored in the palette
    rgb_t pal_rgb;
    // same colour under a sprite shadow
    rgb_t dim_rgb;
    // shadow applies to this word
    logic dim_en;

    // roughly three quarters brightness
    function automatic logic [col_w-1:0] dim(input logic [col_w-1:0] a);
        return a - (a >> 2);
    endfunction

    // nibble gives the top four bits, bits 12..14 the lsb
    always_comb begin
        pal_rgb.red   = {pal_word[3:0],  pal_word[12]};
        pal_rgb.green = {pal_word[7:4],  pal_word[13]};
        pal_rgb.blue  = {pal_word[11:8], pal_word[14]};
    end

    always_comb begin
        dim_rgb.red   = dim(pal_rgb.red);
        dim_rgb.green = dim(pal_rgb.green);
        dim_rgb.blue  = dim(pal_rgb.blue);
    end

    // bit 15 marks colours that stay bright under shadow
    assign dim_en = pal_shadow && !pal_word[15];

    // one pixel after the address, RAM word is settled by now
    always_ff @(posedge clk) begin
        if (reset) begin
            rgb <= '0;
        end else if (pxl_cen) begin
            if (!video_en) begin
                // video off, force black
                rgb <= '0;
            end else if (dim_en) begin
                rgb <= dim_rgb;
            end else begin
                rgb <= pal_rgb;
            end
        end
    end

    // pxl_cen never fires on back-to-back clk
    // so vdata has had a full clk after the address register

endmodule

/* src/video_mixer_top.sv */
// video mixer top: tile/road colour mixing through the shared palette RAM
module video_mixer_top #(
    parameter int blank_dly = 2
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          pxl_cen,
    input  logic                          video_en,
    input  logic                          preLHBL,
    input  logic                          preLVBL,
    // CPU palette access
    input  logic                          pal_cs,
    input  logic [colmix_pkg::pal_aw-1:0] cpu_addr,
    input  logic [15:0]                   cpu_dout,
    input  logic [1:0]                    dswn,
    output logic [15:0]                   cpu_din,
    // layer inputs
    input  logic [10:0]                   tmap_addr,
    input  logic [colmix_pkg::obj_w-1:0]  obj_pxl,
    input  logic [7:0]                    rd_pxl,
    input  logic [1:0]                    rc,
    input  logic                          shadow,
    input  logic                          sa,
    input  logic                          sb,
    input  logic                          fix,
    // video out
    output logic [colmix_pkg::col_w-1:0]  red,
    output logic [colmix_pkg::col_w-1:0]  green,
    output logic [colmix_pkg::col_w-1:0]  blue,
    output logic                          LHBL,
    output logic                          LVBL
);
    import colmix_pkg::*;

    pal_cpu_if cpu_bus ();

    road_mode_e        rc_mode;
    logic [pal_aw-1:0] pal_addr;
    logic              pal_shadow;
    logic [15:0]       pal_word;
    rgb_t              mix_rgb;
    rgb_t              out_rgb;

    // plain CPU ports onto the bus
    assign cpu_bus.cs   = pal_cs;
    assign cpu_bus.addr = cpu_addr;
    assign cpu_bus.dout = cpu_dout;
    assign cpu_bus.dswn = dswn;
    assign cpu_din      = cpu_bus.din;

    assign rc_mode = road_mode_e'(rc);

    layer_select u_sel (
        .clk(clk), .reset(reset), .pxl_cen(pxl_cen), .tmap_addr(tmap_addr),
        .obj_pxl(obj_pxl), .rd_pxl(rd_pxl), .rc(rc_mode), .sa(sa), .sb(sb),
        .fix(fix), .shadow(shadow), .pal_addr(pal_addr), .pal_shadow(pal_shadow)
    );

    pal_ram u_ram (.clk(clk), .cpu(cpu_bus), .vaddr(pal_addr), .vdata(pal_word));

    colmix u_colmix (
        .clk(clk), .reset(reset), .pxl_cen(pxl_cen), .video_en(video_en),
        .pal_word(pal_word), .pal_shadow(pal_shadow), .rgb(mix_rgb)
    );

    blank_delay #(.blank_dly(blank_dly)) u_blank (
        .clk(clk), .reset(reset), .pxl_cen(pxl_cen), .preLHBL(preLHBL),
        .preLVBL(preLVBL), .rgb_in(mix_rgb), .LHBL(LHBL), .LVBL(LVBL),
        .rgb_out(out_rgb)
    );

    assign red   = out_rgb.red;
    assign green = out_rgb.green;
    assign blue  = out_rgb.blue;

endmodule

/* test/clk_gen.sv */
// clock and reset source: 20 ns clock, reset held high over the first two edges
module clk_gen (
    output logic clk,
    output logic reset
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // released on a falling edge, clear of the DUT sampling edge
    initial begin
        reset = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end
endmodule

/* test/tb_video_mixer.sv */
// video mixer testbench: palette load, CPU readback and table-driven pixel checks
module tb_video_mixer;
    timeunit 1ns;
    timeprecision 1ps;
    import colmix_pkg::*;

    localparam int blank_dly = 2;
    localparam int max_px = 18;
    localparam int pal_words = 2048;
    // pixel table, two clk per palette write, margin for reset and CPU tests
    localparam int max_cycles = max_px * 2 * (blank_dly + 4) + pal_words * 2 + 200;

    // one pixel of stimulus with its expected output
    typedef struct packed {
        logic [10:0] tmap;
        logic [obj_w-1:0] obj;
        logic [7:0] rd;
        logic [1:0] rc;
        logic sh, sa, sb, fix, ven, lh, lv;
        rgb_t exp_rgb;
    } pixel_t;

    logic clk, reset, pxl_cen, video_en, preLHBL, preLVBL;
    logic pal_cs, shadow, sa, sb, fix, LHBL, LVBL;
    logic [pal_aw-1:0] cpu_addr;
    logic [15:0] cpu_dout, cpu_din;
    logic [1:0] dswn, rc;
    logic [10:0] tmap_addr;
    logic [obj_w-1:0] obj_pxl;
    logic [7:0] rd_pxl;
    logic [col_w-1:0] red, green, blue;
    rgb_t dut_rgb;
    // palette as the CPU wrote it
    logic [15:0] pal_model [pal_words];
    pixel_t tbl [max_px];
    int n_px = 0;
    int cycles = 0;

    clk_gen u_clk (.clk(clk), .reset(reset));

    video_mixer_top #(.blank_dly(blank_dly)) dut (
        .clk(clk), .reset(reset), .pxl_cen(pxl_cen), .video_en(video_en),
        .preLHBL(preLHBL), .preLVBL(preLVBL), .pal_cs(pal_cs), .cpu_addr(cpu_addr),
        .cpu_dout(cpu_dout), .dswn(dswn), .cpu_din(cpu_din), .tmap_addr(tmap_addr),
        .obj_pxl(obj_pxl), .rd_pxl(rd_pxl), .rc(rc), .shadow(shadow), .sa(sa),
        .sb(sb), .fix(fix), .red(red), .green(green), .blue(blue), .LHBL(LHBL),
        .LVBL(LVBL)
    );

    assign dut_rgb = {red, green, blue};

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic check_rgb(input string name, input rgb_t exp, input rgb_t act);
        if (exp !== act) begin
            abort_run($sformatf("FAILED at %0d ns: %s expected %h/%h/%h got %h/%h/%h",
                $time, name, exp.red, exp.green, exp.blue, act.red, act.green, act.blue));
        end
    endtask

    task automatic check_word(input string name, input logic [15:0] exp, input logic [15:0] act);
        if (exp !== act) begin
            abort_run($sformatf("FAILED at %0d ns: %s expected %h got %h",
                $time, name, exp, act));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            abort_run($sformatf("FAILED at %0d ns: %s expected %b got %b",
                $time, name, exp, act));
        end
    endtask

    // hung run guard
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            abort_run("timeout: the run went past its cycle limit without finishing");
        end
    end

    // colour from a palette word: nibble is the top, bits 12..14 the lsb
    function automatic rgb_t model_colour(input logic [15:0] w, input logic sh,
                                          input logic ven);
        rgb_t c;
        c.red   = {w[3:0], w[12]};
        c.green = {w[7:4], w[13]};
        c.blue  = {w[11:8], w[14]};
        // shadow takes a quarter off, bit 15 exempts
        if (sh && !w[15]) begin
            c.red   = c.red - c.red / 4;
            c.green = c.green - c.green / 4;
            c.blue  = c.blue - c.blue / 4;
        end
        if (!ven) begin
            c = '0;
        end
        return c;
    endfunction

    // palette address from the layer priority rules
    function automatic logic [10:0] model_addr(input logic [10:0] tmap,
            input logic [obj_w-1:0] obj, input logic [7:0] rd, input logic [1:0] rc_in,
            input logic sa_in, input logic sb_in, input logic fix_in);
        logic road;
        logic [1:0] hi;
        road = !fix_in && ((obj[3:0] == 4'h0 && (!rc_in[0] || (!sa_in && !sb_in))) ||
                           (obj[11:10] == 2'b10 && obj[3:0] == 4'b0101));
        hi = (rc_in == 2'b10) ? {1'b0, rd[4]} : (rc_in == 2'b11) ? rd[5:4] : 2'b11;
        return road ? {{5{rc_in[1]}}, hi, rd[3:0]} : tmap;
    endfunction

    task automatic add_pixel(input logic [10:0] tmap, input logic [obj_w-1:0] obj,
            input logic [7:0] rd, input logic [1:0] rc_in, input logic sh,
            input logic sa_in, input logic sb_in, input logic fix_in,
            input logic ven, input logic lh, input logic lv);
        pixel_t p;
        logic [15:0] w;
        p = {tmap, obj, rd, rc_in, sh, sa_in, sb_in, fix_in, ven, lh, lv, 15'h0};
        w = pal_model[model_addr(tmap, obj, rd, rc_in, sa_in, sb_in, fix_in)];
        p.exp_rgb = (lh && lv) ? model_colour(w, sh, ven) : '0;
        tbl[n_px] = p;
        n_px++;
    endtask

    // one CPU cycle, model follows the byte strobes
    task automatic cpu_write(input logic [11:0] a, input logic [15:0] d,
                             input logic [1:0] strobes, input logic sel);
        @(negedge clk);
        pal_cs = sel;
        cpu_addr = a;
        cpu_dout = d;
        dswn = strobes;
        @(negedge clk);
        pal_cs = 1'b0;
        dswn = 2'b11;
        if (sel && !strobes[0]) pal_model[a[10:0]][7:0] = d[7:0];
        if (sel && !strobes[1]) pal_model[a[10:0]][15:8] = d[15:8];
    endtask

    // din is due one clk after the address
    task automatic cpu_read_check(input logic [11:0] a);
        @(negedge clk);
        cpu_addr = a;
        @(negedge clk);
        check_word($sformatf("cpu_din[%h]", a), pal_model[a[10:0]], cpu_din);
    endtask

    task automatic drive_pixel(input int k);
        tmap_addr = tbl[k].tmap;
        obj_pxl = tbl[k].obj;
        rd_pxl = tbl[k].rd;
        rc = tbl[k].rc;
        shadow = tbl[k].sh;
        sa = tbl[k].sa;
        sb = tbl[k].sb;
        fix = tbl[k].fix;
        preLHBL = tbl[k].lh;
        preLVBL = tbl[k].lv;
    endtask

    initial begin
        void'($urandom(48));
        {pxl_cen, pal_cs, shadow, sa, sb, fix} = '0;
        {video_en, preLHBL, preLVBL} = 3'b111;
        {cpu_addr, cpu_dout, tmap_addr, obj_pxl, rd_pxl, rc} = '0;
        dswn = 2'b11;
        wait (!reset);
        @(negedge clk);
        check_bit("LHBL", 1'b0, LHBL);
        check_bit("LVBL", 1'b0, LVBL);
        check_rgb("rgb", '0, dut_rgb);
        // random palette over the whole 11-bit range
        for (int a = 0; a < pal_words; a++) begin
            cpu_write(a, $urandom, 2'b00, 1'b1);
        end
        for (int a = 0; a < pal_words; a += 257) cpu_read_check(a);
        // full word, lower byte, upper byte, then a write without cs
        cpu_write(12'h100, 16'h5a3c, 2'b00, 1'b1);
        cpu_read_check(12'h100);
        cpu_write(12'h100, 16'hff99, 2'b10, 1'b1);
        cpu_read_check(12'h100);
        cpu_write(12'h101, 16'hc7aa, 2'b01, 1'b1);
        cpu_read_check(12'h101);
        cpu_write(12'h102, 16'h1234, 2'b00, 1'b0);
        cpu_read_check(12'h102);
        // tmap, obj, rd, rc, shadow, sa, sb, fix, video_en, LHBL, LVBL
        add_pixel(11'h123, 13'h0000, 8'h00, 2'b00, 0, 0, 0, 1, 1, 1, 1);
        add_pixel(11'h2a5, 13'h0007, 8'h3a, 2'b00, 0, 0, 0, 0, 1, 1, 1);
        add_pixel(11'h555, 13'h0c05, 8'h3a, 2'b00, 0, 0, 0, 0, 1, 1, 1);
        add_pixel(11'h7f0, 13'h0000, 8'h11, 2'b11, 0, 1, 0, 0, 1, 1, 1);
        add_pixel(11'h3c3, 13'h0010, 8'h22, 2'b01, 0, 0, 1, 0, 1, 1, 1);
        // road, all four modes and both rules
        add_pixel(11'h123, 13'h0000, 8'h3a, 2'b00, 0, 1, 1, 0, 1, 1, 1);
        add_pixel(11'h123, 13'h0000, 8'h25, 2'b01, 0, 0, 0, 0, 1, 1, 1);
        add_pixel(11'h123, 13'h0000, 8'h1c, 2'b10, 0, 1, 1, 0, 1, 1, 1);
        add_pixel(11'h123, 13'h0805, 8'h2b, 2'b11, 0, 1, 0, 0, 1, 1, 1);
        add_pixel(11'h123, 13'h0000, 8'h17, 2'b11, 0, 0, 0, 0, 1, 1, 1);
        // shadow on a plain word, an exempt word, then no shadow
        add_pixel(11'h100, 13'h0001, 8'h00, 2'b00, 1, 0, 0, 0, 1, 1, 1);
        add_pixel(11'h101, 13'h0001, 8'h00, 2'b00, 1, 0, 0, 0, 1, 1, 1);
        add_pixel(11'h100, 13'h0001, 8'h00, 2'b00, 0, 0, 0, 0, 1, 1, 1);
        // video off, then blanking
        add_pixel(11'h2a5, 13'h0001, 8'h00, 2'b00, 0, 0, 0, 1, 0, 1, 1);
        add_pixel(11'h123, 13'h0001, 8'h00, 2'b00, 0, 0, 0, 1, 1, 0, 1);
        add_pixel(11'h123, 13'h0000, 8'h3a, 2'b00, 0, 0, 0, 0, 1, 1, 0);
        add_pixel(11'h123, 13'h0001, 8'h00, 2'b00, 0, 0, 0, 1, 1, 0, 0);
        add_pixel(11'h400, 13'h0001, 8'h00, 2'b00, 0, 0, 0, 1, 1, 1, 1);
        // pixel k enters on its pxl_cen, output due blank_dly+1 enables later
        for (int k = 0; k < n_px + blank_dly + 1; k++) begin
            @(negedge clk);
            if (k < n_px) drive_pixel(k);
            // colmix samples video_en one pixel after the address
            video_en = (k > 0 && k <= n_px) ? tbl[k-1].ven : 1'b1;
            pxl_cen = 1'b1;
            @(negedge clk);
            pxl_cen = 1'b0;
            if (k >= blank_dly + 1) begin
                check_bit($sformatf("LHBL[%0d]", k - blank_dly - 1),
                          tbl[k-blank_dly-1].lh, LHBL);
                check_bit($sformatf("LVBL[%0d]", k - blank_dly - 1),
                          tbl[k-blank_dly-1].lv, LVBL);
                check_rgb($sformatf("rgb[%0d]", k - blank_dly - 1),
                          tbl[k-blank_dly-1].exp_rgb, dut_rgb);
            end
        end
        $display("TEST RESULT: PASS");
        $finish;
    end
endmodule

/* verilog.f */
src/colmix_pkg.sv
src/pal_cpu_if.sv
src/pal_ram.sv
src/layer_select.sv
src/blank_delay.sv
src/colmix.sv
src/video_mixer_top.sv
test/clk_gen.sv
test/tb_video_mixer.sv
